/* design/rdp_consts.svh */
/* sizes shared by the tile read pipeline
   slot count and FIFO depths are assumed to be at least 2 */
`ifndef RDP_CONSTS_SVH
`define RDP_CONSTS_SVH

// DRAM word address and data word widths
`define RDP_ADDR_BW    16
`define RDP_DATA_BW    16
// words per DRAM beat, also per output row
`define RDP_VSIZE      4
// tile shape and buffering
`define RDP_ROWS       4
`define RDP_NSLOT      2
`define RDP_COORD_BW   8
`define RDP_CMDQ_DEPTH 4
// derived index widths
`define RDP_ROW_BW     ($clog2(`RDP_ROWS))
`define RDP_SLOT_BW    ($clog2(`RDP_NSLOT))
`define RDP_CMDQ_BW    ($clog2(`RDP_CMDQ_DEPTH))

`endif

/* design/rdp_pkg.sv */
/* types shared by the read pipeline RTL and its testbench
   sizes come from rdp_consts.svh */
`include "rdp_consts.svh"

package rdp_pkg;

	// one DRAM beat or one output row
	typedef logic [`RDP_VSIZE-1:0][`RDP_DATA_BW-1:0] vec_t;

	typedef logic [`RDP_SLOT_BW-1:0] slot_t;

	typedef struct packed {
		logic [`RDP_ADDR_BW-1:0]  base;
		logic [`RDP_ADDR_BW-1:0]  stride;
		logic [`RDP_COORD_BW-1:0] height;
		logic [`RDP_DATA_BW-1:0]  pad;
	} cfg_t;

	typedef enum logic [1:0] {CFG_BASE, CFG_STRIDE, CFG_HEIGHT, CFG_PAD} cfg_reg_e;

	// top-left corner of a tile
	typedef struct packed {
		logic [`RDP_COORD_BW-1:0] row;
		logic [`RDP_COORD_BW-1:0] col;
	} blk_req_t;

	typedef enum logic {ROW_READ, ROW_PAD} row_kind_e;

	typedef struct packed {
		row_kind_e               kind;
		slot_t                   slot;
		logic [`RDP_ROW_BW-1:0]  row;
		logic                    last;
	} wr_cmd_t;

	typedef struct packed {
		vec_t data;
		logic last;
	} out_beat_t;

endpackage

/* design/rdp_cfg_regs.sv */
/* configuration registers, zero after reset
   change only while the pipeline is idle; nothing checks this */
`include "rdp_consts.svh"

module rdp_cfg_regs (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_cfg_we,
	input  rdp_pkg::cfg_reg_e       i_cfg_idx,
	input  logic [`RDP_DATA_BW-1:0] i_cfg_wdata,
	output rdp_pkg::cfg_t           o_cfg
);

// ============================================================
// register file
// ============================================================
// each field keeps only the low bits it has room for
always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		o_cfg <= '0;
	end else if (i_cfg_we) begin
		unique case (i_cfg_idx)
			rdp_pkg::CFG_BASE: begin
				o_cfg.base <= i_cfg_wdata[`RDP_ADDR_BW-1:0];
			end
			rdp_pkg::CFG_STRIDE: begin
				o_cfg.stride <= i_cfg_wdata[`RDP_ADDR_BW-1:0];
			end
			rdp_pkg::CFG_HEIGHT: begin
				o_cfg.height <= i_cfg_wdata[`RDP_COORD_BW-1:0];
			end
			rdp_pkg::CFG_PAD: begin
				o_cfg.pad <= i_cfg_wdata[`RDP_DATA_BW-1:0];
			end
		endcase
	end
end

endmodule

/* design/rdp_slot_alloc.sv */
/* hands out tile buffer slots in round-robin order
   relies on slots being retired in the order they were granted */
`include "rdp_consts.svh"

module rdp_slot_alloc (
	input  logic           i_clk,
	input  logic           i_rst,
	input  logic           i_blk_valid,
	output logic           o_grant_valid,
	output rdp_pkg::slot_t o_grant_slot,
	input  logic           i_grant_ready,
	input  logic           i_retire,
	input  rdp_pkg::slot_t i_retire_slot,
	output logic           o_has_free
);

logic [`RDP_NSLOT-1:0] busy;
rdp_pkg::slot_t        ptr;
logic                  grant_fire;

assign grant_fire   = o_grant_valid & i_grant_ready;
// the pointer only moves on a grant, so it names the granted slot
assign o_grant_slot = ptr;
assign o_has_free   = ~busy[ptr];

// busy bit per slot
always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		busy <= '0;
	end else begin
		for (int i = 0; i < `RDP_NSLOT; i++) begin
			if (grant_fire && ptr == rdp_pkg::slot_t'(i)) begin
				busy[i] <= 1'b1;
			end else if (i_retire && i_retire_slot == rdp_pkg::slot_t'(i)) begin
				busy[i] <= 1'b0;
			end
		end
	end
end

// grant one cycle after a block waits and the next slot is free
always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		ptr           <= '0;
		o_grant_valid <= 1'b0;
	end else if (grant_fire) begin
		o_grant_valid <= 1'b0;
		if (ptr == rdp_pkg::slot_t'(`RDP_NSLOT - 1)) begin
			ptr <= '0;
		end else begin
			ptr <= ptr + 1'b1;
		end
	end else if (!o_grant_valid && i_blk_valid && !busy[ptr]) begin
		o_grant_valid <= 1'b1;
	end
end

endmodule

/* design/rdp_chunk_addr.sv */
/* walks the rows of one granted block, one row per cycle at best
   rows at or past the image height become pad rows with no DRAM read */
`include "rdp_consts.svh"

module rdp_chunk_addr (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  rdp_pkg::cfg_t           i_cfg,
	input  logic                    i_blk_valid,
	input  rdp_pkg::blk_req_t       i_blk,
	output logic                    o_blk_ready,
	input  logic                    i_grant_valid,
	input  rdp_pkg::slot_t          i_grant_slot,
	output logic                    o_grant_ready,
	output logic                    o_cmd_valid,
	output rdp_pkg::wr_cmd_t        o_cmd,
	input  logic                    i_cmd_ready,
	output logic                    o_dram_valid,
	output logic [`RDP_ADDR_BW-1:0] o_dram_addr,
	input  logic                    i_dram_ready
);

typedef enum logic {WK_IDLE, WK_RUN} walk_state_e;

walk_state_e              state;
rdp_pkg::blk_req_t        blk_q;
rdp_pkg::slot_t           slot_q;
logic [`RDP_ROW_BW-1:0]   row_q;
logic                     cmd_taken;
logic                     addr_taken;
logic                     blk_fire;
logic                     running;
logic                     is_read;
logic                     is_last;
logic                     cmd_done;
logic                     addr_done;
logic                     row_adv;
logic [`RDP_COORD_BW:0]   img_row;
logic [`RDP_ADDR_BW-1:0]  img_row_addr;
logic [`RDP_ADDR_BW-1:0]  col_addr;

// block and grant are taken together
assign o_blk_ready   = (state == WK_IDLE) & i_grant_valid;
assign o_grant_ready = (state == WK_IDLE) & i_blk_valid;
assign blk_fire      = o_blk_ready & i_blk_valid;
assign running       = (state == WK_RUN);

// ============================================================
// row classification and address
// ============================================================
// one extra bit so rows near the bottom coordinate do not wrap
assign img_row = {1'b0, blk_q.row} + {{(`RDP_COORD_BW + 1 - `RDP_ROW_BW){1'b0}}, row_q};
assign is_read = img_row < {1'b0, i_cfg.height};
assign is_last = (row_q == `RDP_ROWS - 1);

assign img_row_addr = {{(`RDP_ADDR_BW - `RDP_COORD_BW - 1){1'b0}}, img_row};
assign col_addr     = {{(`RDP_ADDR_BW - `RDP_COORD_BW){1'b0}}, blk_q.col};
assign o_dram_addr  = i_cfg.base + img_row_addr * i_cfg.stride + col_addr;

assign o_cmd.kind = is_read ? rdp_pkg::ROW_READ : rdp_pkg::ROW_PAD;
assign o_cmd.slot = slot_q;
assign o_cmd.row  = row_q;
assign o_cmd.last = is_last;

// ============================================================
// fork to collector and DRAM
// ============================================================
// taken bits keep either side from seeing the same row twice
assign o_cmd_valid  = running & ~cmd_taken;
assign o_dram_valid = running & is_read & ~addr_taken;
assign cmd_done     = cmd_taken | (o_cmd_valid & i_cmd_ready);
assign addr_done    = ~is_read | addr_taken | (o_dram_valid & i_dram_ready);
assign row_adv      = running & cmd_done & addr_done;

always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		state      <= WK_IDLE;
		cmd_taken  <= 1'b0;
		addr_taken <= 1'b0;
	end else if (blk_fire) begin
		state      <= WK_RUN;
		cmd_taken  <= 1'b0;
		addr_taken <= 1'b0;
	end else if (row_adv) begin
		cmd_taken  <= 1'b0;
		addr_taken <= 1'b0;
		if (is_last) begin
			state <= WK_IDLE;
		end
	end else if (running) begin
		cmd_taken  <= cmd_done;
		addr_taken <= addr_taken | (o_dram_valid & i_dram_ready);
	end
end

// block, slot and row counter
always_ff @(posedge i_clk) begin
	if (blk_fire) begin
		blk_q  <= i_blk;
		slot_q <= i_grant_slot;
		row_q  <= '0;
	end else if (row_adv) begin
		row_q <= row_q + 1'b1;
	end
end

endmodule

/* design/rdp_write_collector.sv */
/* pairs queued row commands with DRAM beats or the pad value
   DRAM beats must return in the order their addresses were issued */
`include "rdp_consts.svh"

module rdp_write_collector (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  rdp_pkg::cfg_t          i_cfg,
	input  logic                   i_cmd_valid,
	input  rdp_pkg::wr_cmd_t       i_cmd,
	output logic                   o_cmd_ready,
	input  logic                   i_dram_rvalid,
	input  rdp_pkg::vec_t          i_dram_rdata,
	output logic                   o_dram_rready,
	output logic                   o_wr_en,
	output rdp_pkg::slot_t         o_wr_slot,
	output logic [`RDP_ROW_BW-1:0] o_wr_row,
	output rdp_pkg::vec_t          o_wr_data,
	output logic                   o_done,
	output rdp_pkg::slot_t         o_done_slot
);

rdp_pkg::wr_cmd_t        cmdq [`RDP_CMDQ_DEPTH];
logic [`RDP_CMDQ_BW-1:0] wr_ptr;
logic [`RDP_CMDQ_BW-1:0] rd_ptr;
logic [`RDP_CMDQ_BW:0]   count;
rdp_pkg::wr_cmd_t        head;
logic                    head_valid;
logic                    head_is_pad;
logic                    push;
logic                    pop;
rdp_pkg::vec_t           pad_vec;

function automatic logic [`RDP_CMDQ_BW-1:0] next_ptr(input logic [`RDP_CMDQ_BW-1:0] p);
	if (p == `RDP_CMDQ_DEPTH - 1) begin
		return '0;
	end
	return p + 1'b1;
endfunction

// ============================================================
// command FIFO
// ============================================================
assign o_cmd_ready = (count != `RDP_CMDQ_DEPTH);
assign push        = i_cmd_valid & o_cmd_ready;
assign pop         = o_wr_en;

always_ff @(posedge i_clk) begin
	if (push) begin
		cmdq[wr_ptr] <= i_cmd;
	end
end

always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count  <= '0;
	end else begin
		if (push) begin
			wr_ptr <= next_ptr(wr_ptr);
		end
		if (pop) begin
			rd_ptr <= next_ptr(rd_ptr);
		end
		case ({push, pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
		endcase
	end
end

// ============================================================
// head of queue to tile buffer
// ============================================================
assign head        = cmdq[rd_ptr];
assign head_valid  = (count != 0);
assign head_is_pad = (head.kind == rdp_pkg::ROW_PAD);

always_comb begin
	for (int k = 0; k < `RDP_VSIZE; k++) begin
		pad_vec[k] = i_cfg.pad;
	end
end

// pad rows go out at once, read rows wait for their beat
assign o_dram_rready = head_valid & ~head_is_pad;
assign o_wr_en       = head_valid & (head_is_pad | i_dram_rvalid);
assign o_wr_slot     = head.slot;
assign o_wr_row      = head.row;
assign o_wr_data     = head_is_pad ? pad_vec : i_dram_rdata;

// last row of a tile marks the slot complete
assign o_done      = o_wr_en & head.last;
assign o_done_slot = head.slot;

endmodule

/* design/rdp_tile_buffer.sv */
/* tile storage, streams finished tiles one row per beat in done order
   the first beat of a tile appears two cycles after its done pulse */
`include "rdp_consts.svh"

module rdp_tile_buffer (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic                   i_wr_en,
	input  rdp_pkg::slot_t         i_wr_slot,
	input  logic [`RDP_ROW_BW-1:0] i_wr_row,
	input  rdp_pkg::vec_t          i_wr_data,
	input  logic                   i_done,
	input  rdp_pkg::slot_t         i_done_slot,
	output logic                   o_rd_valid,
	output rdp_pkg::out_beat_t     o_rd,
	input  logic                   i_rd_ready,
	output logic                   o_retire,
	output rdp_pkg::slot_t         o_retire_slot
);

rdp_pkg::vec_t          tile_mem [`RDP_NSLOT][`RDP_ROWS];
rdp_pkg::slot_t         doneq [`RDP_NSLOT];
rdp_pkg::slot_t         dq_wr;
rdp_pkg::slot_t         dq_rd;
logic [`RDP_SLOT_BW:0]  dq_cnt;
rdp_pkg::slot_t         head_slot;
rdp_pkg::slot_t         out_slot;
logic [`RDP_ROW_BW-1:0] rd_row;
logic                   dq_nonempty;
logic                   out_free;
logic                   load;
logic                   load_last;
logic                   dq_pop;

always_ff @(posedge i_clk) begin
	if (i_wr_en) begin
		tile_mem[i_wr_slot][i_wr_row] <= i_wr_data;
	end
end

// ============================================================
// queue of finished slots
// ============================================================
// never overflows, at most one entry per slot
always_ff @(posedge i_clk) begin
	if (i_done) begin
		doneq[dq_wr] <= i_done_slot;
	end
end

always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		dq_wr  <= '0;
		dq_rd  <= '0;
		dq_cnt <= '0;
	end else begin
		if (i_done) begin
			dq_wr <= (dq_wr == rdp_pkg::slot_t'(`RDP_NSLOT - 1)) ? '0 : dq_wr + 1'b1;
		end
		if (dq_pop) begin
			dq_rd <= (dq_rd == rdp_pkg::slot_t'(`RDP_NSLOT - 1)) ? '0 : dq_rd + 1'b1;
		end
		case ({i_done, dq_pop})
			2'b10: dq_cnt <= dq_cnt + 1'b1;
			2'b01: dq_cnt <= dq_cnt - 1'b1;
			default: dq_cnt <= dq_cnt;
		endcase
	end
end

// ============================================================
// output stage
// ============================================================
assign head_slot   = doneq[dq_rd];
assign dq_nonempty = (dq_cnt != 0);
assign out_free    = ~o_rd_valid | i_rd_ready;
assign load        = dq_nonempty & out_free;
assign load_last   = (rd_row == `RDP_ROWS - 1);
// slot leaves the queue once its last row is loaded
assign dq_pop      = load & load_last;

always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		o_rd_valid <= 1'b0;
		rd_row     <= '0;
	end else begin
		if (out_free) begin
			o_rd_valid <= dq_nonempty;
		end
		if (load) begin
			rd_row <= load_last ? '0 : rd_row + 1'b1;
		end
	end
end

always_ff @(posedge i_clk) begin
	if (load) begin
		o_rd.data <= tile_mem[head_slot][rd_row];
		o_rd.last <= load_last;
		out_slot  <= head_slot;
	end
end

// slot returns to the allocator when its last beat is taken
assign o_retire      = o_rd_valid & i_rd_ready & o_rd.last;
assign o_retire_slot = out_slot;

endmodule

/* design/read_pipeline.sv */
/* tile read pipeline top, tiles come out in block acceptance order
   configuration writes are only safe while the pipeline is idle */
`include "rdp_consts.svh"

module read_pipeline (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_blk_valid,
	input  rdp_pkg::blk_req_t       i_blk,
	output logic                    o_blk_ready,
	output logic                    o_dram_valid,
	output logic [`RDP_ADDR_BW-1:0] o_dram_addr,
	input  logic                    i_dram_ready,
	input  logic                    i_dram_rvalid,
	input  rdp_pkg::vec_t           i_dram_rdata,
	output logic                    o_dram_rready,
	output logic                    o_rd_valid,
	output rdp_pkg::out_beat_t      o_rd,
	input  logic                    i_rd_ready,
	input  logic                    i_cfg_we,
	input  rdp_pkg::cfg_reg_e       i_cfg_idx,
	input  logic [`RDP_DATA_BW-1:0] i_cfg_wdata
);

rdp_pkg::cfg_t          cfg;
logic                   grant_valid;
logic                   grant_ready;
rdp_pkg::slot_t         grant_slot;
logic                   has_free;
logic                   walk_blk_ready;
logic                   cmd_valid;
logic                   cmd_ready;
rdp_pkg::wr_cmd_t       cmd;
logic                   wr_en;
rdp_pkg::slot_t         wr_slot;
logic [`RDP_ROW_BW-1:0] wr_row;
rdp_pkg::vec_t          wr_data;
logic                   done;
rdp_pkg::slot_t         done_slot;
logic                   retire;
rdp_pkg::slot_t         retire_slot;

// a block needs a free slot and an idle walker
assign o_blk_ready = has_free & walk_blk_ready;

rdp_cfg_regs u_cfg (
	.i_clk(i_clk), .i_rst(i_rst),
	.i_cfg_we(i_cfg_we), .i_cfg_idx(i_cfg_idx), .i_cfg_wdata(i_cfg_wdata),
	.o_cfg(cfg)
);

rdp_slot_alloc u_alloc (
	.i_clk(i_clk), .i_rst(i_rst),
	.i_blk_valid(i_blk_valid),
	.o_grant_valid(grant_valid), .o_grant_slot(grant_slot), .i_grant_ready(grant_ready),
	.i_retire(retire), .i_retire_slot(retire_slot),
	.o_has_free(has_free)
);

rdp_chunk_addr u_walk (
	.i_clk(i_clk), .i_rst(i_rst), .i_cfg(cfg),
	.i_blk_valid(i_blk_valid), .i_blk(i_blk), .o_blk_ready(walk_blk_ready),
	.i_grant_valid(grant_valid), .i_grant_slot(grant_slot), .o_grant_ready(grant_ready),
	.o_cmd_valid(cmd_valid), .o_cmd(cmd), .i_cmd_ready(cmd_ready),
	.o_dram_valid(o_dram_valid), .o_dram_addr(o_dram_addr), .i_dram_ready(i_dram_ready)
);

rdp_write_collector u_collect (
	.i_clk(i_clk), .i_rst(i_rst), .i_cfg(cfg),
	.i_cmd_valid(cmd_valid), .i_cmd(cmd), .o_cmd_ready(cmd_ready),
	.i_dram_rvalid(i_dram_rvalid), .i_dram_rdata(i_dram_rdata),
	.o_dram_rready(o_dram_rready),
	.o_wr_en(wr_en), .o_wr_slot(wr_slot), .o_wr_row(wr_row), .o_wr_data(wr_data),
	.o_done(done), .o_done_slot(done_slot)
);

rdp_tile_buffer u_buf (
	.i_clk(i_clk), .i_rst(i_rst),
	.i_wr_en(wr_en), .i_wr_slot(wr_slot), .i_wr_row(wr_row), .i_wr_data(wr_data),
	.i_done(done), .i_done_slot(done_slot),
	.o_rd_valid(o_rd_valid), .o_rd(o_rd), .i_rd_ready(i_rd_ready),
	.o_retire(retire), .o_retire_slot(retire_slot)
);

endmodule

/* sim/tb_clkgen.sv */
/* 8 ns clock, active-low reset held for the first 5 rising edges
   reset is released 1 ns after an edge, like all other stimulus */
module tb_clkgen (
	output logic o_clk,
	output logic o_rst
);
timeunit 1ns;
timeprecision 1ns;

initial begin
	o_clk = 1'b0;
	forever begin
		#4 o_clk = ~o_clk;
	end
end

initial begin
	o_rst = 1'b0;
	repeat (5) @(posedge o_clk);
	#1 o_rst = 1'b1;
end

endmodule

/* sim/tb_read_pipeline.sv */
/* self-checking testbench for read_pipeline with an in-order DRAM model
   stops at the first mismatch; run limited to 40 cycles per tile plus 200 */
`include "rdp_consts.svh"

module tb_read_pipeline;
timeunit 1ns;
timeprecision 1ns;

typedef logic [`RDP_ADDR_BW-1:0]  addr_t;
typedef logic [`RDP_DATA_BW-1:0]  word_t;
typedef logic [`RDP_COORD_BW-1:0] coord_t;

localparam int N_TILES    = 28;
localparam int MAX_CYCLES = 40 * N_TILES + 200;

logic               i_clk;
logic               i_rst;
logic               i_blk_valid;
rdp_pkg::blk_req_t  i_blk;
logic               o_blk_ready;
logic               o_dram_valid;
addr_t              o_dram_addr;
logic               i_dram_ready;
logic               i_dram_rvalid;
rdp_pkg::vec_t      i_dram_rdata;
logic               o_dram_rready;
logic               o_rd_valid;
rdp_pkg::out_beat_t o_rd;
logic               i_rd_ready;
logic               i_cfg_we;
rdp_pkg::cfg_reg_e  i_cfg_idx;
word_t              i_cfg_wdata;

rdp_pkg::out_beat_t exp_q[$];
addr_t              dram_q[$];
rdp_pkg::cfg_t      model_cfg = '0;
logic [31:0]        lfsr_state = 32'h409f92ee;
logic               stall_en = 1'b0;
int                 exp_reads = 0;
int                 dram_addr_cnt = 0;
int                 beat_cnt = 0;

tb_clkgen u_clkgen (.o_clk(i_clk), .o_rst(i_rst));

read_pipeline dut0 (.*);

// ============================================================
// random bits and reference model
// ============================================================
function automatic logic take_bit();
	if (lfsr_state[0]) begin
		lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
	end else begin
		lfsr_state = lfsr_state >> 1;
	end
	return lfsr_state[0];
endfunction

function automatic int take_bits(input int n);
	int v;
	v = 0;
	for (int i = 0; i < n; i++) begin
		v = (v << 1) | int'(take_bit());
	end
	return v;
endfunction

// word k of the beat at address a is a*4+k
function automatic rdp_pkg::vec_t dram_beat(input addr_t addr);
	rdp_pkg::vec_t v;
	for (int k = 0; k < `RDP_VSIZE; k++) begin
		v[k] = word_t'(int'(addr) * `RDP_VSIZE + k);
	end
	return v;
endfunction

function automatic rdp_pkg::out_beat_t expected_beat(input rdp_pkg::cfg_t cfg,
		input rdp_pkg::blk_req_t blk, input int r);
	rdp_pkg::out_beat_t beat;
	int y;
	addr_t addr;
	y = int'(blk.row) + r;
	if (y < int'(cfg.height)) begin
		addr = addr_t'(int'(cfg.base) + y * int'(cfg.stride) + int'(blk.col));
		beat.data = dram_beat(addr);
	end else begin
		for (int k = 0; k < `RDP_VSIZE; k++) begin
			beat.data[k] = cfg.pad;
		end
	end
	beat.last = (r == `RDP_ROWS - 1);
	return beat;
endfunction

function automatic int read_rows(input rdp_pkg::cfg_t cfg, input rdp_pkg::blk_req_t blk);
	int n;
	n = 0;
	for (int r = 0; r < `RDP_ROWS; r++) begin
		if (int'(blk.row) + r < int'(cfg.height)) begin
			n++;
		end
	end
	return n;
endfunction

task automatic abort_run(input string why);
	$display("%s", why);
	$display("SOME TESTS FAILED");
	$fatal(1, "simulation stopped on error");
endtask

// ============================================================
// stimulus tasks entered 1 ns after a rising edge
// ============================================================
task automatic write_cfg(input rdp_pkg::cfg_reg_e idx, input word_t value);
	i_cfg_we    = 1'b1;
	i_cfg_idx   = idx;
	i_cfg_wdata = value;
	@(posedge i_clk);
	#1;
	i_cfg_we = 1'b0;
	// fields keep only their low bits
	case (idx)
		rdp_pkg::CFG_BASE: model_cfg.base = addr_t'(value);
		rdp_pkg::CFG_STRIDE: model_cfg.stride = addr_t'(value);
		rdp_pkg::CFG_HEIGHT: model_cfg.height = coord_t'(value);
		rdp_pkg::CFG_PAD: model_cfg.pad = value;
	endcase
endtask

task automatic send_block(input coord_t row, input coord_t col);
	rdp_pkg::blk_req_t blk;
	logic accepted;
	blk.row     = row;
	blk.col     = col;
	i_blk_valid = 1'b1;
	i_blk       = blk;
	accepted    = 1'b0;
	while (!accepted) begin
		@(negedge i_clk);
		accepted = o_blk_ready;
		@(posedge i_clk);
		#1;
	end
	i_blk_valid = 1'b0;
	for (int r = 0; r < `RDP_ROWS; r++) begin
		exp_q.push_back(expected_beat(model_cfg, blk, r));
	end
	exp_reads += read_rows(model_cfg, blk);
endtask

// drains all tiles, then checks the DRAM address count
task automatic wait_idle();
	while (exp_q.size() != 0) begin
		@(posedge i_clk);
	end
	@(posedge i_clk);
	#1;
	assert (dram_addr_cnt == exp_reads) else
		abort_run($sformatf("[ERROR] %0d ns: DRAM saw %0d addresses, expected %0d",
			$time, dram_addr_cnt, exp_reads));
endtask

// ============================================================
// DRAM model, output checker and watchdog
// ============================================================
// sampled at the falling edge, where every handshake signal is stable
initial begin
	logic addr_fire;
	logic data_fire;
	addr_t addr_now;
	int gap;
	i_dram_ready  = 1'b0;
	i_dram_rvalid = 1'b0;
	i_dram_rdata  = '0;
	gap = 0;
	forever begin
		@(negedge i_clk);
		addr_fire = o_dram_valid & i_dram_ready;
		data_fire = i_dram_rvalid & o_dram_rready;
		addr_now  = o_dram_addr;
		@(posedge i_clk);
		if (addr_fire) begin
			dram_q.push_back(addr_now);
			dram_addr_cnt++;
		end
		#1;
		if (data_fire) begin
			addr_now      = dram_q.pop_front();
			i_dram_rvalid = 1'b0;
			gap           = take_bits(2);
		end
		if (!i_dram_rvalid && dram_q.size() != 0) begin
			if (gap == 0) begin
				i_dram_rvalid = 1'b1;
				i_dram_rdata  = dram_beat(dram_q[0]);
			end else begin
				gap--;
			end
		end
		i_dram_ready = stall_en ? take_bit() : 1'b1;
	end
end

initial begin
	rdp_pkg::out_beat_t got;
	rdp_pkg::out_beat_t want;
	logic fire;
	i_rd_ready = 1'b0;
	forever begin
		@(negedge i_clk);
		fire = o_rd_valid & i_rd_ready;
		got  = o_rd;
		@(posedge i_clk);
		if (fire) begin
			assert (exp_q.size() != 0) else
				abort_run("an output beat arrived with no tile outstanding");
			want = exp_q.pop_front();
			assert (got == want) else
				abort_run($sformatf("[ERROR] %0d ns: beat %0d expected %h, got %h",
					$time, beat_cnt, want, got));
			beat_cnt++;
		end
		#1;
		i_rd_ready = stall_en ? take_bit() : 1'b1;
	end
end

initial begin
	int cycles;
	cycles = 0;
	forever begin
		@(posedge i_clk);
		cycles++;
		if (cycles > MAX_CYCLES) begin
			abort_run("timeout: the tiles did not all come out within the cycle limit");
		end
	end
end

// ============================================================
// test phases
// ============================================================
initial begin
	i_blk_valid = 1'b0;
	i_blk       = '0;
	i_cfg_we    = 1'b0;
	i_cfg_idx   = rdp_pkg::CFG_BASE;
	i_cfg_wdata = '0;
	@(negedge i_clk);
	assert ({o_dram_valid, o_rd_valid, o_dram_rready, o_blk_ready} == 4'b0) else
		abort_run("control outputs are not low during reset");
	@(posedge i_rst);
	@(posedge i_clk);
	#1;
	write_cfg(rdp_pkg::CFG_BASE, 16'h0100);
	write_cfg(rdp_pkg::CFG_STRIDE, 16'h0040);
	write_cfg(rdp_pkg::CFG_HEIGHT, 16'h0020);
	write_cfg(rdp_pkg::CFG_PAD, 16'hbeef);
	// tiles fully inside the image
	send_block(8'd0, 8'd0);
	send_block(8'd4, 8'd8);
	send_block(8'd12, 8'd3);
	wait_idle();
	// tiles crossing or past the bottom edge
	send_block(8'd30, 8'd2);
	send_block(8'd29, 8'd0);
	send_block(8'd36, 8'd6);
	wait_idle();
	// random ready stalls on both sides
	stall_en = 1'b1;
	for (int i = 0; i < 6; i++) begin
		send_block(coord_t'(take_bits(5)), coord_t'(take_bits(6)));
	end
	wait_idle();
	stall_en = 1'b0;
	// more blocks than slots, back to back
	for (int i = 0; i < 12; i++) begin
		send_block(coord_t'(i * 3), coord_t'(i * 5));
	end
	wait_idle();
	// new configuration with the height clipped to 5 and wrapping data words
	write_cfg(rdp_pkg::CFG_BASE, 16'hf000);
	write_cfg(rdp_pkg::CFG_STRIDE, 16'h0113);
	write_cfg(rdp_pkg::CFG_HEIGHT, 16'h0105);
	write_cfg(rdp_pkg::CFG_PAD, 16'h5a5a);
	send_block(8'd0, 8'd0);
	send_block(8'd2, 8'd7);
	send_block(8'd4, 8'd1);
	send_block(8'd250, 8'd9);
	wait_idle();
	if (exp_q.size() == 0 && beat_cnt == N_TILES * `RDP_ROWS && !o_rd_valid
			&& dram_q.size() == 0) begin
		$display("ALL TESTS PASSED");
		$finish;
	end else begin
		abort_run("output or DRAM beats are left over after the last tile");
	end
end

endmodule

/* list.f */
+incdir+design
design/rdp_pkg.sv
design/rdp_cfg_regs.sv
design/rdp_slot_alloc.sv
design/rdp_chunk_addr.sv
design/rdp_write_collector.sv
design/rdp_tile_buffer.sv
design/read_pipeline.sv
sim/tb_clkgen.sv
sim/tb_read_pipeline.sv

/* Makefile */
TOOL      = verilator
FLAGS     = --timing --assert --timescale 1ns/1ps
TOP       = tb_read_pipeline
FLIST     = list.f
BUILD_DIR = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

# the simulator exits with a failing status when the testbench stops on an error
sim:
	$(TOOL) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
